/* dv/syscfg_tb.sv */
`default_nettype none

module syscfg_tb;

    import syscfg_pkg::*;

    localparam int                N_TGTS     = 4;
    localparam logic [N_TGTS-1:0] BOOTSTRAP  = 4'b0001;
    localparam int                ACK_LIMIT  = 8;
    localparam int                POLL_LIMIT = 50;

    logic                          clk;
    logic                          rst_n;
    logic                          req;
    logic                          we;
    logic [7:0]                    addr;
    logic [DATA_W-1:0]             wdata;
    logic                          ack;
    logic                          err;
    logic [DATA_W-1:0]             rdata;
    logic [N_TGTS-1:0]             tgt_rst;
    logic [N_TGTS-1:0]             pause_req;
    logic [N_TGTS-1:0]             pause_ack = '0;
    logic [N_TGTS-1:0][DATA_W-1:0] boot_addr;
    logic [N_TGTS-1:0]             irq;

    // Reference model state and the predicted response.
    st_e                           m_st [N_TGTS];
    logic [N_TGTS-1:0]             m_rst;
    logic [N_TGTS-1:0][DATA_W-1:0] m_boot;
    logic [N_TGTS-1:0]             m_irq;
    logic [N_TGTS-1:0]             exp_preq;
    logic                          p_valid;
    logic                          p_we;
    logic [3:0]                    p_tgt;
    reg_e                          p_reg;
    logic [DATA_W-1:0]             p_wdata;
    logic                          exp_ack;
    logic                          exp_err;
    logic [DATA_W-1:0]             exp_rdata;

    logic                          b_we [8];
    logic [7:0]                    b_addr [8];
    logic [DATA_W-1:0]             b_wdata [8];
    logic [DATA_W-1:0]             last_rdata;
    logic [N_TGTS-1:0]             armed = '0;
    int                            delay [N_TGTS];
    int                            seed = 32'h62b0;
    int                            n_errors = 0;
    int                            n_tests = 0;
    int                            err_base = 0;

    syscfg #(
        .NO_TGTS   (N_TGTS),
        .BOOTSTRAP (BOOTSTRAP),
        .ADDR_W    (8)
    ) uut (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (req),
        .we        (we),
        .addr      (addr),
        .wdata     (wdata),
        .ack       (ack),
        .err       (err),
        .rdata     (rdata),
        .tgt_rst   (tgt_rst),
        .pause_req (pause_req),
        .pause_ack (pause_ack),
        .boot_addr (boot_addr),
        .irq       (irq)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Each subsystem copies pause_req to pause_ack after a random wait.
    always @(posedge clk) begin
        for (int i = 0; i < N_TGTS; i++) begin
            if (pause_req[i] == pause_ack[i]) begin
                armed[i] <= 1'b0;
            end else if (!armed[i]) begin
                armed[i] <= 1'b1;
                delay[i] <= $unsigned($random(seed)) % 6;
            end else if (delay[i] == 0) begin
                pause_ack[i] <= pause_req[i];
            end else begin
                delay[i] <= delay[i] - 1;
            end
        end
    end

    // ********************
    // Reference model
    // ********************

    function automatic logic [DATA_W-1:0] predict_rdata(input int t, input reg_e r);
        logic [DATA_W-1:0] d;
        d = '0;
        if (t < N_TGTS) begin
            case (r)
                REG_STATUS: begin
                    d[1:0] = m_st[t];
                    d[2]   = m_rst[t];
                end
                REG_BOOT_ADDR: d = m_boot[t];
                REG_IRQ:       d[0] = m_irq[t];
                default:       d = '0;
            endcase
        end
        return d;
    endfunction

    // Request stage, answer stage and target update, one clock each.
    always @(posedge clk) begin
        logic hit;
        logic act;
        op_e  op;
        if (!rst_n) begin
            for (int i = 0; i < N_TGTS; i++) begin
                m_st[i] <= BOOTSTRAP[i] ? ST_RUN : ST_PAUSED;
            end
            m_rst   <= ~BOOTSTRAP;
            m_boot  <= '0;
            m_irq   <= '0;
            p_valid <= 1'b0;
            exp_ack <= 1'b0;
            exp_err <= 1'b0;
        end else begin
            exp_ack <= p_valid;
            exp_err <= p_valid && (int'(p_tgt) >= N_TGTS);
            if (p_valid) exp_rdata <= predict_rdata(int'(p_tgt), p_reg);
            op = op_e'(p_wdata[2:0]);
            for (int i = 0; i < N_TGTS; i++) begin
                hit = p_valid && p_we && (int'(p_tgt) == i);
                act = hit && (p_reg == REG_ACTION);
                case (m_st[i])
                    ST_RUN:     if (act && op == OP_PAUSE) m_st[i] <= ST_PAUSING;
                    ST_PAUSING: if (pause_ack[i]) m_st[i] <= ST_PAUSED;
                    ST_PAUSED:  if (act && op == OP_RESUME) m_st[i] <= ST_RESUMING;
                    default:    if (!pause_ack[i]) m_st[i] <= ST_RUN;
                endcase
                if (act && op == OP_RESET && m_st[i] == ST_PAUSED) begin
                    m_rst[i] <= 1'b1;
                end else if (act && op == OP_RELEASE) begin
                    m_rst[i] <= 1'b0;
                end
                if (hit && p_reg == REG_BOOT_ADDR) m_boot[i] <= p_wdata;
                if (hit && p_reg == REG_IRQ) m_irq[i] <= p_wdata[0];
            end
            p_valid <= req;
            p_we    <= we;
            p_tgt   <= addr[7:4];
            p_reg   <= reg_e'(addr[3:2]);
            p_wdata <= wdata;
        end
    end

    always_comb begin
        for (int i = 0; i < N_TGTS; i++) begin
            exp_preq[i] = (m_st[i] == ST_PAUSING) || (m_st[i] == ST_PAUSED);
        end
    end

    function automatic void flag_error(input string msg);
        n_errors++;
        $display("** Error at %0t: %s", $time, msg);
    endfunction

    assert property (@(posedge clk) disable iff (!rst_n) ack == exp_ack)
        else flag_error("ack does not follow the request by two cycles");
    assert property (@(posedge clk) disable iff (!rst_n) err == exp_err)
        else flag_error("err differs from the address map");
    assert property (@(posedge clk) disable iff (!rst_n) ack |-> rdata == exp_rdata)
        else flag_error("rdata differs from the predicted register value");
    assert property (@(posedge clk) disable iff (!rst_n) tgt_rst == m_rst)
        else flag_error("tgt_rst differs from the model");
    assert property (@(posedge clk) disable iff (!rst_n) pause_req == exp_preq)
        else flag_error("pause_req differs from the pause state");
    assert property (@(posedge clk) disable iff (!rst_n) boot_addr == m_boot)
        else flag_error("boot_addr differs from the model");
    assert property (@(posedge clk) disable iff (!rst_n) irq == m_irq)
        else flag_error("irq differs from the model");

    // ********************
    // Bus tasks
    // ********************

    task automatic abort_run(input string msg);
        $display("Timeout at %0t: %s", $time, msg);
        $display("TEST FAILED");
        $finish;
    endtask

    function automatic logic [7:0] reg_addr(input int t, input reg_e r);
        return 8'(t * 16 + int'(r) * 4);
    endfunction

    function automatic void stage_req(input int i, input logic w, input logic [7:0] a,
                                      input logic [DATA_W-1:0] d);
        b_we[i]    = w;
        b_addr[i]  = a;
        b_wdata[i] = d;
    endfunction

    // Issues k staged requests on consecutive cycles and waits for k acks.
    task automatic run_burst(input int k);
        int n;
        int cyc;
        n   = 0;
        cyc = 0;
        for (int i = 0; i < k; i++) begin
            @(posedge clk);
            req   <= 1'b1;
            we    <= b_we[i];
            addr  <= b_addr[i];
            wdata <= b_wdata[i];
            @(negedge clk);
            if (ack) n++;
        end
        @(posedge clk);
        req <= 1'b0;
        while (n < k) begin
            @(negedge clk);
            if (ack) begin
                n++;
                last_rdata = rdata;
            end
            cyc++;
            if (cyc > ACK_LIMIT) abort_run("the bus never acknowledged a request");
        end
    endtask

    task automatic bus_read(input logic [7:0] a);
        stage_req(0, 1'b0, a, '0);
        run_burst(1);
    endtask

    task automatic bus_write(input logic [7:0] a, input logic [DATA_W-1:0] d);
        stage_req(0, 1'b1, a, d);
        run_burst(1);
    endtask

    task automatic bus_action(input int t, input op_e op);
        bus_write(reg_addr(t, REG_ACTION), 32'(op));
    endtask

    task automatic wait_state(input int t, input st_e s);
        int tries;
        tries = 0;
        bus_read(reg_addr(t, REG_STATUS));
        while (last_rdata[1:0] != s) begin
            tries++;
            if (tries > POLL_LIMIT) abort_run("a target never reached the expected state");
            bus_read(reg_addr(t, REG_STATUS));
        end
    endtask

    task automatic finish_test(input string name);
        @(negedge clk);
        n_tests++;
        $display("test %0d %s: %0d errors", n_tests, name, n_errors - err_base);
        err_base = n_errors;
    endtask

    initial begin
        rst_n = 1'b0;
        req   = 1'b0;
        we    = 1'b0;
        addr  = '0;
        wdata = '0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;

        for (int t = 0; t < N_TGTS; t++) begin
            bus_read(reg_addr(t, REG_STATUS));
            bus_read(reg_addr(t, REG_BOOT_ADDR));
            bus_read(reg_addr(t, REG_IRQ));
        end
        finish_test("reset values");

        stage_req(0, 1'b1, reg_addr(3, REG_BOOT_ADDR), 32'h1234_5678);
        stage_req(1, 1'b0, reg_addr(3, REG_BOOT_ADDR), '0);
        stage_req(2, 1'b0, reg_addr(4, REG_STATUS), '0);
        stage_req(3, 1'b1, reg_addr(5, REG_IRQ), 32'h1); // Miss, must not land anywhere.
        stage_req(4, 1'b0, 8'hfc, '0);
        stage_req(5, 1'b0, reg_addr(0, REG_ACTION), '0);
        stage_req(6, 1'b1, reg_addr(2, REG_BOOT_ADDR), 32'hdead_0000);
        run_burst(7);
        finish_test("back-to-back requests");

        bus_write(reg_addr(2, REG_BOOT_ADDR), 32'h8000_1000);
        bus_read(reg_addr(2, REG_BOOT_ADDR));
        bus_write(reg_addr(1, REG_IRQ), 32'hffff_ffff);
        bus_read(reg_addr(1, REG_IRQ));
        bus_write(reg_addr(1, REG_IRQ), 32'h0);
        finish_test("config registers");

        bus_action(0, OP_PAUSE);
        wait_state(0, ST_PAUSED);
        bus_action(0, OP_RESUME);
        wait_state(0, ST_RUN);
        bus_action(3, OP_RESUME);
        wait_state(3, ST_RUN);
        finish_test("pause and resume");

        bus_action(0, OP_RESET);
        bus_read(reg_addr(0, REG_STATUS));
        bus_action(1, OP_RELEASE);
        bus_read(reg_addr(1, REG_STATUS));
        bus_action(1, OP_RESET);
        bus_read(reg_addr(1, REG_STATUS));
        bus_write(reg_addr(1, REG_ACTION), 32'h7); // Unknown opcode.
        bus_action(1, OP_RELEASE);
        bus_read(reg_addr(1, REG_STATUS));
        finish_test("reset control");

        $display("tests run: %0d, errors: %0d", n_tests, n_errors);
        if (n_errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
src/syscfg_pkg.sv
src/syscfg_decode.sv
src/syscfg_tgt.sv
src/syscfg_result.sv
src/syscfg.sv
dv/syscfg_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it from the project root.

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -f filelist.f --top-module syscfg_tb -o syscfg_sim \
    && ./obj_dir/syscfg_sim | tee /dev/stderr | grep -qx "TEST OK" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

/* src/syscfg.sv */
`default_nettype none

module syscfg #(
    parameter int                 NO_TGTS   = 4,
    parameter logic [NO_TGTS-1:0] BOOTSTRAP = NO_TGTS'(1),
    parameter int                 ADDR_W    = 8
) (
    input  logic                                       clk,
    input  logic                                       rst_n,

    input  logic                                       req,
    input  logic                                       we,
    input  logic [ADDR_W-1:0]                          addr,
    input  logic [syscfg_pkg::DATA_W-1:0]              wdata,
    output logic                                       ack,
    output logic                                       err,
    output logic [syscfg_pkg::DATA_W-1:0]              rdata,

    output logic [NO_TGTS-1:0]                         tgt_rst,
    output logic [NO_TGTS-1:0]                         pause_req,
    input  logic [NO_TGTS-1:0]                         pause_ack,
    output logic [NO_TGTS-1:0][syscfg_pkg::DATA_W-1:0] boot_addr,
    output logic [NO_TGTS-1:0]                         irq
);

    import syscfg_pkg::*;

    localparam int IDX_W = (NO_TGTS > 1) ? $clog2(NO_TGTS) : 1;

    logic [NO_TGTS-1:0]             tgt_sel;
    reg_e                           reg_sel;
    logic                           wr;
    logic [DATA_W-1:0]              wr_data;
    logic                           rd_valid;
    logic                           rd_miss;
    logic [IDX_W-1:0]               rd_tgt;
    logic [NO_TGTS-1:0][DATA_W-1:0] tgt_rd_data;

    // ********************
    // Decode
    // ********************

    syscfg_decode #(
        .NO_TGTS (NO_TGTS),
        .ADDR_W  (ADDR_W),
        .IDX_W   (IDX_W)
    ) u_decode (
        .clk      (clk),
        .rst_n    (rst_n),
        .req      (req),
        .we       (we),
        .addr     (addr),
        .wdata    (wdata),
        .tgt_sel  (tgt_sel),
        .reg_sel  (reg_sel),
        .wr       (wr),
        .wr_data  (wr_data),
        .rd_valid (rd_valid),
        .rd_miss  (rd_miss),
        .rd_tgt   (rd_tgt)
    );

    // ********************
    // Target array
    // ********************

    for (genvar i = 0; i < NO_TGTS; i++) begin : g_tgt
        syscfg_tgt #(
            .BOOT (BOOTSTRAP[i])
        ) u_tgt (
            .clk       (clk),
            .rst_n     (rst_n),
            .sel       (tgt_sel[i]),
            .reg_sel   (reg_sel),
            .wr        (wr),
            .wr_data   (wr_data),
            .rd_data   (tgt_rd_data[i]),
            .tgt_rst   (tgt_rst[i]),
            .pause_req (pause_req[i]),
            .pause_ack (pause_ack[i]),
            .boot_addr (boot_addr[i]),
            .irq       (irq[i])
        );
    end

    syscfg_result #(
        .NO_TGTS (NO_TGTS),
        .IDX_W   (IDX_W)
    ) u_result (
        .clk         (clk),
        .rst_n       (rst_n),
        .rd_valid    (rd_valid),
        .rd_miss     (rd_miss),
        .rd_tgt      (rd_tgt),
        .tgt_rd_data (tgt_rd_data),
        .rdata       (rdata),
        .ack         (ack),
        .err         (err)
    );

endmodule

`default_nettype wire

/* src/syscfg_decode.sv */
`default_nettype none

module syscfg_decode #(
    parameter int NO_TGTS = 4,
    parameter int ADDR_W  = 8,
    parameter int IDX_W   = 2
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          req,
    input  logic                          we,
    input  logic [ADDR_W-1:0]             addr,
    input  logic [syscfg_pkg::DATA_W-1:0] wdata,
    output logic [NO_TGTS-1:0]            tgt_sel,
    output syscfg_pkg::reg_e              reg_sel,
    output logic                          wr,
    output logic [syscfg_pkg::DATA_W-1:0] wr_data,
    output logic                          rd_valid,
    output logic                          rd_miss,
    output logic [IDX_W-1:0]              rd_tgt
);

    import syscfg_pkg::*;

    localparam int TIDX_W = ADDR_W - 4; // Each target owns 16 bytes.

    logic [TIDX_W-1:0]  tgt_idx;
    logic               hit;
    logic [NO_TGTS-1:0] sel_d;

    assign tgt_idx = addr[ADDR_W-1:4];
    assign hit     = int'(tgt_idx) < NO_TGTS;

    always_comb begin
        sel_d = '0;
        for (int i = 0; i < NO_TGTS; i++) begin
            sel_d[i] = (int'(tgt_idx) == i);
        end
    end

    // ********************
    // Request register
    // ********************

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tgt_sel  <= '0;
            wr       <= 1'b0;
            rd_valid <= 1'b0;
        end else begin
            tgt_sel  <= req ? sel_d : '0;
            wr       <= req && we && hit; // Writes outside the map are dropped.
            rd_valid <= req;
        end
    end

    always_ff @(posedge clk) begin
        if (req) begin
            reg_sel <= reg_e'(addr[REG_W+1:2]);
            wr_data <= wdata;
            rd_miss <= !hit;
            rd_tgt  <= IDX_W'(tgt_idx);
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n) $onehot0(tgt_sel));

endmodule

`default_nettype wire

/* src/syscfg_pkg.sv */
`default_nettype none

package syscfg_pkg;

    // ********************
    // Bus widths
    // ********************

    localparam int DATA_W = 32;
    localparam int REG_W  = 2; // Register select field, address bits 3:2.

    // ********************
    // Encodings
    // ********************

    // Register offsets inside one target's 16-byte window.
    typedef enum logic [REG_W-1:0] {
        REG_ACTION,
        REG_STATUS,
        REG_BOOT_ADDR,
        REG_IRQ
    } reg_e;

    // Commands written to REG_ACTION, taken from the low bits of the data.
    typedef enum logic [2:0] {
        OP_NOP,
        OP_PAUSE,
        OP_RESUME,
        OP_RESET,
        OP_RELEASE
    } op_e;

    typedef enum logic [1:0] {
        ST_RUN,
        ST_PAUSING,
        ST_PAUSED,
        ST_RESUMING
    } st_e;

endpackage

`default_nettype wire

/* src/syscfg_result.sv */
`default_nettype none

module syscfg_result #(
    parameter int NO_TGTS = 4,
    parameter int IDX_W   = 2
) (
    input  logic                                       clk,
    input  logic                                       rst_n,
    input  logic                                       rd_valid,
    input  logic                                       rd_miss,
    input  logic [IDX_W-1:0]                           rd_tgt,
    input  logic [NO_TGTS-1:0][syscfg_pkg::DATA_W-1:0] tgt_rd_data,
    output logic [syscfg_pkg::DATA_W-1:0]              rdata,
    output logic                                       ack,
    output logic                                       err
);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ack <= 1'b0;
            err <= 1'b0;
        end else begin
            ack <= rd_valid; // Writes are acknowledged like reads.
            err <= rd_valid && rd_miss;
        end
    end

    // The target word is sampled before any write on this edge lands.
    always_ff @(posedge clk) begin
        if (rd_valid) begin
            rdata <= rd_miss ? '0 : tgt_rd_data[rd_tgt];
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n) err |-> ack);

endmodule

`default_nettype wire

/* src/syscfg_tgt.sv */
`default_nettype none

module syscfg_tgt #(
    parameter bit BOOT = 1'b0
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          sel,
    input  syscfg_pkg::reg_e              reg_sel,
    input  logic                          wr,
    input  logic [syscfg_pkg::DATA_W-1:0] wr_data,
    output logic [syscfg_pkg::DATA_W-1:0] rd_data,
    output logic                          tgt_rst,
    output logic                          pause_req,
    input  logic                          pause_ack,
    output logic [syscfg_pkg::DATA_W-1:0] boot_addr,
    output logic                          irq
);

    import syscfg_pkg::*;

    st_e  st;
    op_e  op;
    logic wr_act;
    logic wr_boot;
    logic wr_irq;

    assign op      = op_e'(wr_data[2:0]);
    assign wr_act  = sel && wr && (reg_sel == REG_ACTION);
    assign wr_boot = sel && wr && (reg_sel == REG_BOOT_ADDR);
    assign wr_irq  = sel && wr && (reg_sel == REG_IRQ);

    // ********************
    // Pause FSM
    // ********************

    // A bootstrap target leaves reset running, all others stay parked.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            st        <= BOOT ? ST_RUN : ST_PAUSED;
            pause_req <= !BOOT;
        end else begin
            case (st)
                ST_RUN: begin
                    if (wr_act && op == OP_PAUSE) begin
                        st        <= ST_PAUSING;
                        pause_req <= 1'b1;
                    end
                end
                ST_PAUSING: begin
                    if (pause_ack) st <= ST_PAUSED;
                end
                ST_PAUSED: begin
                    if (wr_act && op == OP_RESUME) begin
                        st        <= ST_RESUMING;
                        pause_req <= 1'b0;
                    end
                end
                ST_RESUMING: begin
                    if (!pause_ack) st <= ST_RUN; // Subsystem has let go.
                end
                default: st <= ST_RUN;
            endcase
        end
    end

    // Reset may only be applied to a subsystem that is fully paused.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tgt_rst <= !BOOT;
        end else if (wr_act && op == OP_RESET && st == ST_PAUSED) begin
            tgt_rst <= 1'b1;
        end else if (wr_act && op == OP_RELEASE) begin
            tgt_rst <= 1'b0;
        end
    end

    // ********************
    // Config registers
    // ********************

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            boot_addr <= '0;
            irq       <= 1'b0;
        end else begin
            if (wr_boot) boot_addr <= wr_data;
            if (wr_irq) irq <= wr_data[0];
        end
    end

    always_comb begin
        rd_data = '0;
        case (reg_sel)
            REG_STATUS: begin
                rd_data[1:0] = st;
                rd_data[2]   = tgt_rst;
            end
            REG_BOOT_ADDR: rd_data = boot_addr;
            REG_IRQ:       rd_data[0] = irq;
            default:       rd_data = '0; // The action register reads as zero.
        endcase
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        $rose(tgt_rst) |-> $past(st) == ST_PAUSED);

    assert property (@(posedge clk) disable iff (!rst_n)
        pause_req == (st == ST_PAUSING || st == ST_PAUSED));

endmodule

`default_nettype wire
